// File: src/exec_pkg.sv
// Shared widths, operation and unit encodings, unit input and stage result structs
package exec_pkg;

    parameter int XLEN = 32;                // Data path width

    ////////////////////////////////////////////////////////////////////
    // Operation codes
    ////////////////////////////////////////////////////////////////////
    typedef enum logic [4:0] {
        OP_NOP,                             // Idle, unit holds
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU,    // Arithmetic and compare
        OP_AND, OP_OR, OP_XOR,              // Bitwise logic
        OP_SLL, OP_SRL, OP_SRA,             // Shifts by op_b[4:0]
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE,     // Conditional branches
        OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR,                    // Unconditional jumps
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW
    } exec_op_e;

    ////////////////////////////////////////////////////////////////////
    // Execute unit selector
    ////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        XU_INT,                             // Integer ALU
        XU_BRANCH,                          // Branch and jump
        XU_MEM,                             // Load and store
        XU_BYPASS,                          // op_b straight to write-back
        XU_NONE                             // Idle slot
    } exec_unit_e;

    // Operands handed to one functional unit
    typedef struct packed {
        exec_op_e        op;                // Operation code
        logic [XLEN-1:0] op_a;              // First source
        logic [XLEN-1:0] op_b;              // Second source or store data
        logic [XLEN-1:0] op_c;              // Immediate offset
        logic [XLEN-1:0] npc;               // Next PC of the instruction
    } unit_in_t;

    // What the stage hands to write-back and memory retire
    typedef struct packed {
        logic [XLEN-1:0] res0;              // Write-back value or store data
        logic [XLEN-1:0] res1;              // Branch target or store address
        logic            jump;              // Redirect fetch
        logic            we;                // Register file write enable
        logic            write;             // Store retires this cycle
        logic [1:0]      size;              // 1 byte, 2 half, 3 word
    } exec_result_t;

endpackage

// File: src/exec_dispatch.sv
// Operand dispatcher steering one operation to the unit that owns it
`timescale 1ns/1ps

module exec_dispatch import exec_pkg::*; (
    input  exec_unit_e      unit_i,         // Target unit of this operation
    input  exec_op_e        op_i,           // Operation code
    input  logic [XLEN-1:0] op_a_i,         // First source
    input  logic [XLEN-1:0] op_b_i,         // Second source
    input  logic [XLEN-1:0] op_c_i,         // Immediate
    input  logic [XLEN-1:0] npc_i,          // Next PC
    output unit_in_t        int_o,          // To integer unit
    output unit_in_t        br_o,           // To branch unit
    output unit_in_t        mem_o           // To memory unit
);

    localparam unit_in_t UNIT_IDLE = '{op: OP_NOP, default: '0};

    unit_in_t issue;

    assign issue = '{op: op_i, op_a: op_a_i, op_b: op_b_i, op_c: op_c_i, npc: npc_i};

    always_comb begin
        int_o = UNIT_IDLE;                  // Everyone idles by default
        br_o  = UNIT_IDLE;
        mem_o = UNIT_IDLE;
        case (unit_i)
            XU_INT:    int_o = issue;
            XU_BRANCH: br_o  = issue;
            XU_MEM:    mem_o = issue;
            default: ;                      // Bypass and idle need no unit
        endcase
    end

    // Each unit only ever sees its own operations
    always_comb begin
        assert #0 ((int_o.op inside {OP_NOP, [OP_ADD:OP_SRA]})
                && (br_o.op inside {OP_NOP, [OP_BEQ:OP_JALR]})
                && (mem_o.op inside {OP_NOP, [OP_LB:OP_SW]}))
            else $error("operation dispatched to a unit that does not own it");
    end

endmodule

// File: src/int_unit.sv
// Integer unit with adder, set-less-than compare, bitwise logic and barrel shifter
`timescale 1ns/1ps

module int_unit import exec_pkg::*; (
    input  logic            clk,
    input  unit_in_t        unit_i,         // Operands from dispatcher
    output logic [XLEN-1:0] result_o        // Registered result
);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] res_next;
    logic            busy;

    assign a     = unit_i.op_a;
    assign b     = unit_i.op_b;
    assign shamt = unit_i.op_b[4:0];        // Only low five bits count

    ////////////////////////////////////////////////////////////////////
    // Arithmetic and compare
    ////////////////////////////////////////////////////////////////////
    assign sum  = a + b;
    assign diff = a - b;
    assign lt_s = $signed(a) < $signed(b);  // SLT
    assign lt_u = a < b;                    // SLTU

    ////////////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        res_next = result_o;                // Hold on anything not ours
        busy     = 1'b1;
        case (unit_i.op)
            OP_ADD:  res_next = sum;
            OP_SUB:  res_next = diff;
            OP_SLT:  res_next = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU: res_next = {{(XLEN-1){1'b0}}, lt_u};
            OP_AND:  res_next = a & b;
            OP_OR:   res_next = a | b;
            OP_XOR:  res_next = a ^ b;
            OP_SLL:  res_next = a << shamt;
            OP_SRL:  res_next = a >> shamt;
            OP_SRA:  res_next = $unsigned($signed(a) >>> shamt);  // Sign fill
            default: busy = 1'b0;           // NOP keeps old value
        endcase
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            result_o <= res_next;
        end
    end

endmodule

// File: src/branch_unit.sv
// Branch unit computing condition, target and link value, all registered
`timescale 1ns/1ps

module branch_unit import exec_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  unit_in_t        unit_i,         // Operands from dispatcher
    output logic [XLEN-1:0] link_o,         // Return address, npc
    output logic [XLEN-1:0] target_o,       // Redirect address
    output logic            jump_o          // Taken branch or jump
);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] target_next;
    logic            taken;

    assign a        = unit_i.op_a;
    assign b        = unit_i.op_b;
    assign jalr_sum = a + unit_i.op_c;

    always_comb begin
        target_next = unit_i.npc - XLEN'(4) + unit_i.op_c;  // PC relative
        taken       = 1'b0;
        case (unit_i.op)
            OP_BEQ:  taken = (a == b);
            OP_BNE:  taken = (a != b);
            OP_BLT:  taken = ($signed(a) < $signed(b));
            OP_BGE:  taken = ($signed(a) >= $signed(b));
            OP_BLTU: taken = (a < b);
            OP_BGEU: taken = (a >= b);
            OP_JAL:  taken = 1'b1;
            OP_JALR: begin
                taken       = 1'b1;
                target_next = {jalr_sum[XLEN-1:1], 1'b0};  // Clear bit 0
            end
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            jump_o <= 1'b0;
        end else begin
            jump_o <= taken;                // NOP drops the jump
        end
    end

    always_ff @(posedge clk) begin
        if (unit_i.op != OP_NOP) begin
            link_o   <= unit_i.npc;         // Link is simply npc
            target_o <= target_next;
        end
    end

endmodule

// File: src/mem_unit.sv
// Memory unit with address and read strobe, store registers and load extension
`timescale 1ns/1ps

module mem_unit import exec_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  unit_in_t        unit_i,         // Operands from dispatcher
    input  logic [XLEN-1:0] mem_data_i,     // Word returned one cycle after read
    output logic [XLEN-1:0] mem_addr_o,     // Read address, issue cycle
    output logic            mem_read_o,     // Read strobe, issue cycle
    output logic [XLEN-1:0] st_addr_o,      // Store address
    output logic [XLEN-1:0] st_data_o,      // Store data
    output logic [1:0]      st_size_o,      // 1 byte, 2 half, 3 word
    output logic            st_write_o,     // Store retires
    output logic [XLEN-1:0] ld_data_o       // Extended load value
);

    logic [XLEN-1:0] addr;
    logic            is_load;
    logic            is_store;
    logic [1:0]      size_next;
    exec_op_e        ld_op_q;               // Load kind waiting for data
    logic [1:0]      ld_off_q;              // Byte offset within word
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;

    assign addr = unit_i.op_a + unit_i.op_c;

    ////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        is_load   = unit_i.op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
        is_store  = unit_i.op inside {OP_SB, OP_SH, OP_SW};
        size_next = 2'd0;
        case (unit_i.op)
            OP_SB:   size_next = 2'd1;
            OP_SH:   size_next = 2'd2;
            OP_SW:   size_next = 2'd3;
            default: size_next = 2'd0;
        endcase
    end

    assign mem_addr_o = addr;
    assign mem_read_o = is_load;            // Memory answers next cycle

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            st_write_o <= 1'b0;
            st_size_o  <= 2'd0;
            ld_op_q    <= OP_NOP;
        end else begin
            st_write_o <= is_store;
            st_size_o  <= size_next;
            ld_op_q    <= is_load ? unit_i.op : OP_NOP;
        end
    end

    always_ff @(posedge clk) begin
        ld_off_q <= addr[1:0];
        if (is_store) begin
            st_addr_o <= addr;
            st_data_o <= unit_i.op_b;       // Raw register value
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Load alignment and extension
    ////////////////////////////////////////////////////////////////////
    assign ld_byte = mem_data_i[ld_off_q*8 +: 8];
    assign ld_half = mem_data_i[ld_off_q[1]*16 +: 16];

    always_comb begin
        case (ld_op_q)
            OP_LB:   ld_data_o = {{(XLEN-8){ld_byte[7]}}, ld_byte};
            OP_LBU:  ld_data_o = {{(XLEN-8){1'b0}}, ld_byte};
            OP_LH:   ld_data_o = {{(XLEN-16){ld_half[15]}}, ld_half};
            OP_LHU:  ld_data_o = {{(XLEN-16){1'b0}}, ld_half};
            OP_LW:   ld_data_o = mem_data_i;
            default: ld_data_o = '0;
        endcase
    end

    // Loads arrive naturally aligned, no misaligned trap here
    assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_read_o |-> !((unit_i.op inside {OP_LH, OP_LHU} && addr[0])
                         || (unit_i.op == OP_LW && addr[1:0] != 2'd0)))
        else $error("misaligned load issued");

endmodule

// File: src/exec_collect.sv
// Collector with stage-2 selector, tag register and result demultiplexer
`timescale 1ns/1ps

module exec_collect import exec_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  exec_unit_e       unit_i,        // Unit of the issuing op
    input  exec_op_e         op_i,          // Needed for we decision
    input  logic [TAG_W-1:0] tag_i,
    input  logic [XLEN-1:0]  int_res_i,
    input  logic [XLEN-1:0]  br_link_i,
    input  logic [XLEN-1:0]  br_target_i,
    input  logic             br_jump_i,
    input  logic [XLEN-1:0]  st_addr_i,
    input  logic [XLEN-1:0]  st_data_i,
    input  logic [1:0]       st_size_i,
    input  logic             st_write_i,
    input  logic [XLEN-1:0]  ld_data_i,
    input  logic [XLEN-1:0]  bypass_i,      // op_b for bypass ops
    output exec_result_t     result_o,
    output logic [TAG_W-1:0] tag_o
);

    exec_unit_e      sel_q;                 // Unit of the op now completing
    logic            link_q;                // JAL or JALR
    logic            load_q;                // Any load
    logic [XLEN-1:0] bypass_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sel_q  <= XU_NONE;
            tag_o  <= '0;
            link_q <= 1'b0;
            load_q <= 1'b0;
        end else begin
            sel_q  <= unit_i;
            tag_o  <= tag_i;
            link_q <= op_i inside {OP_JAL, OP_JALR};
            load_q <= op_i inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
        end
    end

    always_ff @(posedge clk) begin
        if (unit_i == XU_BYPASS) begin
            bypass_q <= bypass_i;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Result demux, unselected fields stay zero
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        result_o = '0;
        case (sel_q)
            XU_INT: begin
                result_o.res0 = int_res_i;
                result_o.we   = 1'b1;
            end
            XU_BRANCH: begin
                result_o.res0 = br_link_i;
                result_o.res1 = br_target_i;
                result_o.jump = br_jump_i;
                result_o.we   = link_q;     // Only jumps link
            end
            XU_MEM: begin
                result_o.res0  = st_write_i ? st_data_i : ld_data_i;
                result_o.res1  = st_write_i ? st_addr_i : '0;
                result_o.write = st_write_i;
                result_o.size  = st_size_i;
                result_o.we    = load_q;
            end
            XU_BYPASS: begin
                result_o.res0 = bypass_q;
                result_o.we   = 1'b1;
            end
            default: ;                      // Idle slot
        endcase
    end

    // A memory slot retires as exactly one of load or store
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (sel_q == XU_MEM) |-> (load_q != result_o.write))
        else $error("memory slot is neither a single load nor a store");

endmodule

// File: src/exec_stage.sv
// Execute stage top with dispatcher, integer, branch and memory units, collector
`timescale 1ns/1ps

module exec_stage import exec_pkg::*; #(
    parameter int TAG_W = 4                 // Instruction tag width
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  exec_unit_e       unit_i,
    input  exec_op_e         op_i,
    input  logic [XLEN-1:0]  op_a_i,
    input  logic [XLEN-1:0]  op_b_i,
    input  logic [XLEN-1:0]  op_c_i,
    input  logic [XLEN-1:0]  npc_i,
    input  logic [TAG_W-1:0] tag_i,
    input  logic [XLEN-1:0]  mem_data_i,    // Load data, cycle after read
    output exec_result_t     result_o,
    output logic [TAG_W-1:0] tag_o,
    output logic [XLEN-1:0]  mem_addr_o,
    output logic             mem_read_o
);

    unit_in_t        int_in, br_in, mem_in;
    logic [XLEN-1:0] int_res;
    logic [XLEN-1:0] br_link, br_target;
    logic            br_jump;
    logic [XLEN-1:0] st_addr, st_data, ld_data;
    logic [1:0]      st_size;
    logic            st_write;

    //////////////////////////////////////////////////////////////////////
    exec_dispatch u_dispatch (.unit_i(unit_i), .op_i(op_i), .op_a_i(op_a_i), .op_b_i(op_b_i),
        .op_c_i(op_c_i), .npc_i(npc_i), .int_o(int_in), .br_o(br_in), .mem_o(mem_in));

    int_unit u_int (.clk(clk), .unit_i(int_in), .result_o(int_res));

    branch_unit u_branch (.clk(clk), .rst_n_i(rst_n_i), .unit_i(br_in),
        .link_o(br_link), .target_o(br_target), .jump_o(br_jump));

    mem_unit u_mem (.clk(clk), .rst_n_i(rst_n_i), .unit_i(mem_in), .mem_data_i(mem_data_i),
        .mem_addr_o(mem_addr_o), .mem_read_o(mem_read_o), .st_addr_o(st_addr),
        .st_data_o(st_data), .st_size_o(st_size), .st_write_o(st_write), .ld_data_o(ld_data));

    // Bypass takes op_b straight to the collector
    exec_collect #(.TAG_W(TAG_W)) u_collect (.clk(clk), .rst_n_i(rst_n_i), .unit_i(unit_i),
        .op_i(op_i), .tag_i(tag_i), .int_res_i(int_res), .br_link_i(br_link),
        .br_target_i(br_target), .br_jump_i(br_jump), .st_addr_i(st_addr),
        .st_data_i(st_data), .st_size_i(st_size), .st_write_i(st_write),
        .ld_data_i(ld_data), .bypass_i(op_b_i), .result_o(result_o), .tag_o(tag_o));

endmodule

// File: tests/tb_exec_stage.sv
// Testbench for exec_stage with directed tests, LFSR stimulus, reference model and compare tasks
`timescale 1ns/1ps

module tb_exec_stage import exec_pkg::*; ();

    localparam int          TAG_W     = 4;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32+x^22+x^2+x+1

    logic             clk;
    logic             rst_n_i = 1'b0;
    exec_unit_e       unit_i  = XU_NONE;
    exec_op_e         op_i    = OP_NOP;
    logic [XLEN-1:0]  op_a_i  = '0;
    logic [XLEN-1:0]  op_b_i  = '0;
    logic [XLEN-1:0]  op_c_i  = '0;
    logic [XLEN-1:0]  npc_i   = '0;
    logic [TAG_W-1:0] tag_i   = '0;
    logic [XLEN-1:0]  mem_data_i = '0;
    exec_result_t     result_o;
    logic [TAG_W-1:0] tag_o;
    logic [XLEN-1:0]  mem_addr_o;
    logic             mem_read_o;

    logic [31:0]      lfsr = 32'h238e;
    logic             rd_pend = 1'b0;       // Memory model saw a read
    logic [XLEN-1:0]  rd_addr = '0;
    exec_result_t     exp_res;              // Expected result of the op in flight
    logic [TAG_W-1:0] exp_tag;
    logic             has_pend = 1'b0;
    string            pend_name;
    int               test_errs  = 0;
    int               total_errs = 0;
    int               n_tests    = 0;
    int               n_checks   = 0;

    exec_stage #(.TAG_W(TAG_W)) dut (.clk(clk), .rst_n_i(rst_n_i), .unit_i(unit_i),
        .op_i(op_i), .op_a_i(op_a_i), .op_b_i(op_b_i), .op_c_i(op_c_i), .npc_i(npc_i),
        .tag_i(tag_i), .mem_data_i(mem_data_i), .result_o(result_o), .tag_o(tag_o),
        .mem_addr_o(mem_addr_o), .mem_read_o(mem_read_o));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Memory model, one cycle read latency
    //////////////////////////////////////////////////////////////////////
    function automatic logic [XLEN-1:0] mem_fill(logic [XLEN-1:0] addr);
        logic [XLEN-1:0] w;
        w = {addr[XLEN-1:2], 2'b00};        // Word address
        return (w * 32'h9E37_79B9) ^ {w[15:0], w[31:16]};
    endfunction

    always @(posedge clk) begin
        rd_pend <= mem_read_o;
        rd_addr <= mem_addr_o;
    end

    always @(negedge clk) begin
        mem_data_i <= rd_pend ? mem_fill(rd_addr) : '0;  // Word back in cycle N+1
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ LFSR_TAPS;
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic exec_result_t model_result(exec_unit_e u, exec_op_e op,
            logic [XLEN-1:0] a, logic [XLEN-1:0] b, logic [XLEN-1:0] c,
            logic [XLEN-1:0] npc);
        exec_result_t    r;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] w;
        logic [7:0]      by;
        logic [15:0]     hw;
        r    = '0;
        addr = a + c;                       // Load/store and JALR sum
        w    = mem_fill(addr);
        by   = w[8*addr[1:0] +: 8];
        hw   = w[16*addr[1] +: 16];
        case (u)
            XU_INT: begin
                r.we = 1'b1;
                case (op)
                    OP_ADD:  r.res0 = a + b;
                    OP_SUB:  r.res0 = a - b;
                    OP_SLT:  r.res0 = XLEN'($signed(a) < $signed(b));
                    OP_SLTU: r.res0 = XLEN'(a < b);
                    OP_AND:  r.res0 = a & b;
                    OP_OR:   r.res0 = a | b;
                    OP_XOR:  r.res0 = a ^ b;
                    OP_SLL:  r.res0 = a << b[4:0];
                    OP_SRL:  r.res0 = a >> b[4:0];
                    default: r.res0 = (a >> b[4:0])  // SRA, vacated bits take the sign
                                    | ({XLEN{a[XLEN-1]}} & ~(32'hFFFF_FFFF >> b[4:0]));
                endcase
            end
            XU_BRANCH: begin
                r.res0 = npc;                // Link value
                r.res1 = (op == OP_JALR) ? (addr & ~32'h1) : npc - 32'd4 + c;
                r.we   = op inside {OP_JAL, OP_JALR};
                case (op)
                    OP_BEQ:  r.jump = (a == b);
                    OP_BNE:  r.jump = (a != b);
                    OP_BLT:  r.jump = ($signed(a) < $signed(b));
                    OP_BGE:  r.jump = ($signed(a) >= $signed(b));
                    OP_BLTU: r.jump = (a < b);
                    OP_BGEU: r.jump = (a >= b);
                    default: r.jump = 1'b1;  // JAL, JALR
                endcase
            end
            XU_MEM: begin
                r.we = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
                case (op)
                    OP_LB:   r.res0 = {{24{by[7]}}, by};
                    OP_LBU:  r.res0 = {24'd0, by};
                    OP_LH:   r.res0 = {{16{hw[15]}}, hw};
                    OP_LHU:  r.res0 = {16'd0, hw};
                    OP_LW:   r.res0 = w;
                    default: begin           // Stores
                        r.res0  = b;
                        r.res1  = addr;
                        r.write = 1'b1;
                        r.size  = (op == OP_SB) ? 2'd1 : (op == OP_SH) ? 2'd2 : 2'd3;
                    end
                endcase
            end
            XU_BYPASS: begin
                r.res0 = b;
                r.we   = 1'b1;
            end
            default: ;                       // Idle, all zero
        endcase
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_result(string name, exec_result_t exp, exec_result_t act);
        n_checks++;
        if (act !== exp) begin
            test_errs++;
            $display("Fail %s result expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_tag(string name, logic [TAG_W-1:0] exp, logic [TAG_W-1:0] act);
        n_checks++;
        if (act !== exp) begin
            test_errs++;
            $display("Fail %s tag expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        n_checks++;
        if (act !== exp) begin
            test_errs++;
            $display("Fail %s address expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        n_checks++;
        if (act !== exp) begin
            test_errs++;
            $display("Fail %s read strobe expected %b actual %b", name, exp, act);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Issue and retire
    //////////////////////////////////////////////////////////////////////
    task automatic retire();
        if (has_pend) begin
            check_result(pend_name, exp_res, result_o);
            check_tag(pend_name, exp_tag, tag_o);
            has_pend = 1'b0;
        end
    endtask

    task automatic issue(string name, exec_unit_e u, exec_op_e op, logic [XLEN-1:0] a,
            logic [XLEN-1:0] b, logic [XLEN-1:0] c, logic [XLEN-1:0] npc);
        logic rd_exp;
        rd_exp    = (u == XU_MEM) && (op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW});
        unit_i    = u;
        op_i      = op;
        op_a_i    = a;
        op_b_i    = b;
        op_c_i    = c;
        npc_i     = npc;
        tag_i     = TAG_W'(rand_bits(TAG_W));
        #1;                                 // Memory data and read strobe settle
        retire();                           // Previous op is on result_o now
        check_bit(name, rd_exp, mem_read_o);
        if (rd_exp) check_word(name, a + c, mem_addr_o);
        exp_res   = model_result(u, op, a, b, c, npc);
        exp_tag   = tag_i;
        pend_name = name;
        has_pend  = 1'b1;
    endtask

    task automatic step();
        @(negedge clk);                     // Next op goes in on the falling edge
    endtask

    function automatic exec_op_e pick_op(exec_unit_e u);
        case (u)
            XU_INT:    return exec_op_e'(5'(OP_ADD + rand_bits(4) % 10));
            XU_BRANCH: return exec_op_e'(5'(OP_BEQ + rand_bits(3)));  // Up to JALR
            XU_MEM:    return exec_op_e'(5'(OP_LB + rand_bits(3)));   // Up to SW
            default:   return OP_NOP;
        endcase
    endfunction

    task automatic issue_random(string name, exec_unit_e u);
        exec_op_e        op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] c;
        op = pick_op(u);
        a  = rand_bits(32);
        c  = rand_bits(32);
        if (op inside {OP_LH, OP_LHU}) a = a - ((a + c) & 32'h1);  // Aligned half
        if (op == OP_LW) a = a - ((a + c) & 32'h3);
        issue(name, u, op, a, rand_bits(32), c, rand_bits(32));
    endtask

    task automatic finish_test(string name);
        issue(name, XU_NONE, OP_NOP, '0, '0, '0, '0);  // Idle slot retires the last op
        step();
        issue(name, XU_NONE, OP_NOP, '0, '0, '0, '0);  // Second idle slot retires the first
        has_pend = 1'b0;
        step();
        n_tests++;
        total_errs += test_errs;
        if (test_errs == 0) $display("%s: ok", name);
        else $display("%s: %0d errors", name, test_errs);
        test_errs = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////
    task automatic test_reset();
        check_result("reset", '0, result_o);
        check_tag("reset", '0, tag_o);
        check_bit("reset", 1'b0, mem_read_o);
        finish_test("reset");
    endtask

    task automatic test_int();
        for (int i = 0; i < 30; i++) begin
            issue_random("int_ops", XU_INT);
            step();
        end
        finish_test("int_ops");
    endtask

    task automatic test_branch();
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] pa [4];
        logic [XLEN-1:0] pb [4];
        for (int op = OP_BEQ; op <= OP_BGEU; op++) begin
            x  = rand_bits(30);
            pa = '{x, x, x + 1, 32'hFFFF_FF00 | x};  // Equal, less, greater, sign split
            pb = '{x, x + 1, x, x};
            for (int k = 0; k < 4; k++) begin
                issue("branch", XU_BRANCH, exec_op_e'(op), pa[k], pb[k], rand_bits(32),
                      rand_bits(32) & ~32'h3);
                step();
            end
        end
        issue("branch", XU_BRANCH, OP_JAL, rand_bits(32), rand_bits(32), rand_bits(32),
              rand_bits(32));
        step();
        issue("branch", XU_BRANCH, OP_JALR, rand_bits(32), rand_bits(32), rand_bits(32),
              rand_bits(32));
        step();
        finish_test("branch");
    endtask

    task automatic test_load();
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] c;
        for (int op = OP_LB; op <= OP_LW; op++) begin
            for (int off = 0; off < 4; off++) begin
                if (!((op inside {OP_LH, OP_LHU} && off[0]) || (op == OP_LW && off != 0))) begin
                    base = rand_bits(32) & ~32'h3;
                    c    = rand_bits(12);
                    issue("load", XU_MEM, exec_op_e'(op), base + off - c, rand_bits(32), c,
                          rand_bits(32));
                    step();
                end
            end
        end
        finish_test("load");
    endtask

    task automatic test_store();
        for (int op = OP_SB; op <= OP_SW; op++) begin
            for (int i = 0; i < 3; i++) begin
                issue("store", XU_MEM, exec_op_e'(op), rand_bits(32), rand_bits(32),
                      rand_bits(32), rand_bits(32));
                step();
            end
        end
        finish_test("store");
    endtask

    task automatic test_mixed();
        for (int i = 0; i < 4; i++) begin
            issue_random("bypass", XU_BYPASS);
            step();
        end
        for (int i = 0; i < 60; i++) begin
            issue_random("mixed", exec_unit_e'(3'(rand_bits(3) % 5)));
            step();
        end
        finish_test("bypass_mixed");
    endtask

    initial begin
        repeat (2) @(posedge clk);          // Reset held for two cycles
        @(negedge clk);
        rst_n_i = 1'b1;
        test_reset();
        test_int();
        test_branch();
        test_load();
        test_store();
        test_mixed();
        $display("Tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, total_errs);
        if (total_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog for a run that stops advancing
    initial begin
        repeat (5000) @(posedge clk);
        $display("Watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: exec_stage.f
src/exec_pkg.sv
src/exec_dispatch.sv
src/int_unit.sv
src/branch_unit.sv
src/mem_unit.sv
src/exec_collect.sv
src/exec_stage.sv
tests/tb_exec_stage.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_exec_stage -f exec_stage.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_exec_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -x "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
